// ==== mem_back_defines.svh ====
`ifndef MEM_BACK_DEFINES_SVH
`define MEM_BACK_DEFINES_SVH

// Data path and program counter width
`define MB_DATA_W 32

// Byte lanes in one data word
`define MB_BE_W (`MB_DATA_W / 8)

// General purpose register index width
`define MB_REG_AW 5

// Data RAM word address width, 256 words give 1 KiB
`define MB_RAM_AW 8

// Data RAM depth in words
`define MB_RAM_DEPTH (1 << `MB_RAM_AW)

`endif

// ==== exc_pkg.sv ====
`default_nettype none

`include "mem_back_defines.svh"

package exc_pkg;

    // Cause flags raised by earlier stages and carried with the instruction
    typedef struct packed {
        logic in_delay_slot;
        logic is_int;
        logic is_inst_adel;
        logic is_ri;
        logic is_overflow;
        logic is_syscall;
        logic is_break;
        logic is_eret;
    } exc_flags_t;

    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } exc_code_e;

    // Resolved exception as seen by the CP0 register file
    typedef struct packed {
        logic                  valid;
        exc_code_e             code;
        logic [`MB_DATA_W-1:0] epc;
        logic [`MB_DATA_W-1:0] bad_vaddr;
    } exc_report_t;

endpackage

`default_nettype wire

// ==== pipe_pkg.sv ====
`default_nettype none

`include "mem_back_defines.svh"

package pipe_pkg;

    // Codes below 8 are loads, codes from 8 up are stores
    typedef enum logic [3:0] {
        LS_LB  = 4'h0,
        LS_LBU = 4'h1,
        LS_LH  = 4'h2,
        LS_LHU = 4'h3,
        LS_LW  = 4'h4,
        LS_SB  = 4'h8,
        LS_SH  = 4'h9,
        LS_SW  = 4'hA
    } ls_sel_e;

    typedef struct packed {
        logic [`MB_DATA_W-1:0] pc;
        logic [`MB_DATA_W-1:0] alu_res;
        logic [`MB_DATA_W-1:0] ls_addr;
        logic [`MB_DATA_W-1:0] rt_data;
        logic                  w_reg_ena;
        logic [`MB_REG_AW-1:0] w_reg_dst;
        logic                  ls_ena;
        ls_sel_e               ls_sel;
        logic                  wb_reg_sel; // Set when the register takes memory data
        exc_pkg::exc_flags_t   exc;
    } ex_result_t;

    typedef struct packed {
        logic [`MB_DATA_W-1:0] alu_res;
        logic [1:0]            byte_off;
        ls_sel_e               ls_sel;
        logic                  is_load;
        logic                  w_reg_ena;
        logic [`MB_REG_AW-1:0] w_reg_dst;
        logic                  wb_reg_sel;
    } lsu_result_t;

    typedef struct packed {
        logic                  we;
        logic                  re;
        logic [`MB_BE_W-1:0]   be;
        logic [`MB_RAM_AW-1:0] addr;
        logic [`MB_DATA_W-1:0] wdata;
    } ram_req_t;

    typedef struct packed {
        logic                  w_reg_ena;
        logic [`MB_REG_AW-1:0] w_reg_dst;
        logic [`MB_DATA_W-1:0] data;
    } wb_t;

endpackage

`default_nettype wire

// ==== pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire      clk,
    input  wire      arst_n_i,
    input  wire      stall_i,
    input  wire      flush_i,
    input  wire      exc_flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t q_r;

    // An exception flush wins over a stall, a plain flush does not
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_r <= '0;
        end else if (exc_flush_i || (flush_i && !stall_i)) begin
            q_r <= '0; // Inserts a bubble
        end else if (!stall_i) begin
            q_r <= d_i;
        end
    end

    assign q_o = q_r;

endmodule

`default_nettype wire

// ==== exc_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module exc_arbiter (
    input  pipe_pkg::ex_result_t ex_i,
    input  wire                  data_adel_i,
    input  wire                  data_ades_i,
    output exc_pkg::exc_report_t exc_o,
    output logic                 eret_o
);

    // First matching cause wins, in MIPS priority order
    always_comb begin
        exc_o       = '0;
        exc_o.valid = 1'b1;
        if (ex_i.exc.is_int) begin
            exc_o.code = exc_pkg::EXC_INT;
        end else if (ex_i.exc.is_inst_adel) begin
            exc_o.code      = exc_pkg::EXC_ADEL;
            exc_o.bad_vaddr = ex_i.pc; // Fetch address was bad
        end else if (ex_i.exc.is_ri) begin
            exc_o.code = exc_pkg::EXC_RI;
        end else if (ex_i.exc.is_overflow) begin
            exc_o.code = exc_pkg::EXC_OV;
        end else if (ex_i.exc.is_syscall) begin
            exc_o.code = exc_pkg::EXC_SYS;
        end else if (ex_i.exc.is_break) begin
            exc_o.code = exc_pkg::EXC_BP;
        end else if (data_adel_i) begin
            exc_o.code      = exc_pkg::EXC_ADEL;
            exc_o.bad_vaddr = ex_i.ls_addr;
        end else if (data_ades_i) begin
            exc_o.code      = exc_pkg::EXC_ADES;
            exc_o.bad_vaddr = ex_i.ls_addr;
        end else begin
            exc_o.valid = 1'b0;
        end

        // A delay-slot instruction restarts at its branch
        if (exc_o.valid) begin
            exc_o.epc = ex_i.exc.in_delay_slot ? ex_i.pc - 4 : ex_i.pc;
        end
    end

    assign eret_o = ex_i.exc.is_eret && !exc_o.valid;

endmodule

`default_nettype wire

// ==== lsu_addr_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_back_defines.svh"

module lsu_addr_stage (
    input  pipe_pkg::ex_result_t  ex_i,
    output logic                  data_adel_o,
    output logic                  data_ades_o,
    output pipe_pkg::ram_req_t    ram_req_o,
    output pipe_pkg::lsu_result_t lsu_o
);

    logic [1:0] off;
    logic       is_load;
    logic       is_store;
    logic       misalign;

    assign off      = ex_i.ls_addr[1:0];
    assign is_load  = ex_i.ls_ena && !ex_i.ls_sel[3];
    assign is_store = ex_i.ls_ena && ex_i.ls_sel[3];

    always_comb begin
        misalign = 1'b0;
        case (ex_i.ls_sel)
            pipe_pkg::LS_LH, pipe_pkg::LS_LHU, pipe_pkg::LS_SH: misalign = off[0];
            pipe_pkg::LS_LW, pipe_pkg::LS_SW:                   misalign = |off;
            default:                                            misalign = 1'b0;
        endcase
    end

    assign data_adel_o = is_load && misalign;
    assign data_ades_o = is_store && misalign;

    // Store data is copied into every lane, the enables pick the live ones
    always_comb begin
        ram_req_o       = '0;
        ram_req_o.we    = is_store;
        ram_req_o.re    = is_load;
        ram_req_o.addr  = ex_i.ls_addr[`MB_RAM_AW+1:2];
        ram_req_o.wdata = ex_i.rt_data;
        if (is_store) begin
            case (ex_i.ls_sel)
                pipe_pkg::LS_SB: begin
                    ram_req_o.be    = `MB_BE_W'(1) << off;
                    ram_req_o.wdata = {`MB_BE_W{ex_i.rt_data[7:0]}};
                end
                pipe_pkg::LS_SH: begin
                    ram_req_o.be    = off[1] ? 4'b1100 : 4'b0011;
                    ram_req_o.wdata = {2{ex_i.rt_data[15:0]}};
                end
                default: ram_req_o.be = '1;
            endcase
        end
    end

    always_comb begin
        lsu_o            = '0;
        lsu_o.alu_res    = ex_i.alu_res;
        lsu_o.byte_off   = off;
        lsu_o.ls_sel     = ex_i.ls_sel;
        lsu_o.is_load    = is_load;
        lsu_o.w_reg_ena  = ex_i.w_reg_ena;
        lsu_o.w_reg_dst  = ex_i.w_reg_dst;
        lsu_o.wb_reg_sel = ex_i.wb_reg_sel;
    end

endmodule

`default_nettype wire

// ==== data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_back_defines.svh"

module data_ram (
    input  wire                   clk,
    input  wire                   re_i,
    input  wire                   we_i,
    input  wire [`MB_BE_W-1:0]    be_i,
    input  wire [`MB_RAM_AW-1:0]  addr_i,
    input  wire [`MB_DATA_W-1:0]  wdata_i,
    output logic [`MB_DATA_W-1:0] rdata_o
);

    logic [`MB_DATA_W-1:0] mem [`MB_RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int i = 0; i < `MB_BE_W; i++) begin
                if (be_i[i]) begin
                    mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end
        end
    end

    // Output holds its value whenever no read is issued
    always_ff @(posedge clk) begin
        if (re_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

`default_nettype wire

// ==== load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_back_defines.svh"

module load_align (
    input  pipe_pkg::lsu_result_t lsu_i,
    input  wire [`MB_DATA_W-1:0]  rdata_i,
    output pipe_pkg::wb_t         wb_o
);

    logic [`MB_DATA_W-1:0] lane;
    logic [7:0]            byte_v;
    logic [15:0]           half_v;
    logic [`MB_DATA_W-1:0] mem_val;

    assign lane   = rdata_i >> (8 * lsu_i.byte_off);
    assign byte_v = lane[7:0];
    assign half_v = lsu_i.byte_off[1] ? rdata_i[31:16] : rdata_i[15:0];

    always_comb begin
        case (lsu_i.ls_sel)
            pipe_pkg::LS_LB:  mem_val = {{(`MB_DATA_W - 8){byte_v[7]}}, byte_v};
            pipe_pkg::LS_LBU: mem_val = {{(`MB_DATA_W - 8){1'b0}}, byte_v};
            pipe_pkg::LS_LH:  mem_val = {{(`MB_DATA_W - 16){half_v[15]}}, half_v};
            pipe_pkg::LS_LHU: mem_val = {{(`MB_DATA_W - 16){1'b0}}, half_v};
            default:          mem_val = rdata_i;
        endcase
    end

    // Memory data only reaches the register for a real load
    always_comb begin
        wb_o           = '0;
        wb_o.w_reg_ena = lsu_i.w_reg_ena;
        wb_o.w_reg_dst = lsu_i.w_reg_dst;
        wb_o.data      = (lsu_i.wb_reg_sel && lsu_i.is_load) ? mem_val : lsu_i.alu_res;
    end

endmodule

`default_nettype wire

// ==== mem_back_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_back_defines.svh"

module mem_back_top (
    input  wire                  clk,
    input  wire                  arst_n_i,
    input  wire                  stall_i,
    input  wire                  flush_i,
    input  pipe_pkg::ex_result_t ex_i,
    output pipe_pkg::wb_t        wb_o,
    output exc_pkg::exc_report_t exc_o,
    output logic                 eret_o
);

    pipe_pkg::ex_result_t  ex_q;
    pipe_pkg::lsu_result_t lsu_d;
    pipe_pkg::lsu_result_t lsu_q;
    pipe_pkg::ram_req_t    ram_req;
    logic                  ram_we;
    logic                  ram_re;
    logic [`MB_DATA_W-1:0] ram_rdata;
    logic                  data_adel;
    logic                  data_ades;
    logic                  exception_flush;

    pipe_reg #(.payload_t(pipe_pkg::ex_result_t)) ex_lsu1 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .stall_i    (stall_i),
        .flush_i    (flush_i),
        .exc_flush_i(exception_flush),
        .d_i        (ex_i),
        .q_o        (ex_q)
    );

    lsu_addr_stage lsu1 (
        .ex_i       (ex_q),
        .data_adel_o(data_adel),
        .data_ades_o(data_ades),
        .ram_req_o  (ram_req),
        .lsu_o      (lsu_d)
    );

    exc_arbiter exc_arb (
        .ex_i       (ex_q),
        .data_adel_i(data_adel),
        .data_ades_i(data_ades),
        .exc_o      (exc_o),
        .eret_o     (eret_o)
    );

    assign exception_flush = exc_o.valid || eret_o;

    // A faulting store never reaches memory, a stalled access waits
    assign ram_we = ram_req.we && !exception_flush && !stall_i;
    assign ram_re = ram_req.re && !stall_i;

    data_ram dram (
        .clk    (clk),
        .re_i   (ram_re),
        .we_i   (ram_we),
        .be_i   (ram_req.be),
        .addr_i (ram_req.addr),
        .wdata_i(ram_req.wdata),
        .rdata_o(ram_rdata)
    );

    pipe_reg #(.payload_t(pipe_pkg::lsu_result_t)) lsu1_lsu2 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .stall_i    (stall_i),
        .flush_i    (flush_i),
        .exc_flush_i(exception_flush),
        .d_i        (lsu_d),
        .q_o        (lsu_q)
    );

    load_align lsu2 (
        .lsu_i  (lsu_q),
        .rdata_i(ram_rdata),
        .wb_o   (wb_o)
    );

endmodule

`default_nettype wire

// ==== mem_back_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_back_asserts #(
    parameter int W = 1
) (
    input wire         clk,
    input wire         arst_n_i,
    input wire         stall_i,
    input wire         flush_i,
    input wire         exc_flush_i,
    input wire [W-1:0] d_i,
    input wire [W-1:0] q_o
);

    // A cleared stage carries no write enable, so nothing behind a fault writes back
    exc_flush_clears: assert property (@(posedge clk) disable iff (!arst_n_i)
        exc_flush_i |=> q_o == '0)
        else $error("Exception flush left a live payload in %m");

    flush_clears: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i && !stall_i |=> q_o == '0)
        else $error("Flush without stall left a live payload in %m");

    stall_holds: assert property (@(posedge clk) disable iff (!arst_n_i)
        stall_i && !exc_flush_i |=> $stable(q_o))
        else $error("Stage changed under stall in %m");

    free_loads: assert property (@(posedge clk) disable iff (!arst_n_i)
        !stall_i && !flush_i && !exc_flush_i |=> q_o == $past(d_i))
        else $error("Stage did not load its input in %m");

endmodule

bind pipe_reg mem_back_asserts #(.W($bits(payload_t))) pipe_reg_chk (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .stall_i    (stall_i),
    .flush_i    (flush_i),
    .exc_flush_i(exc_flush_i),
    .d_i        (d_i),
    .q_o        (q_o)
);

`default_nettype wire

// ==== mem_back_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_back_defines.svh"

module mem_back_tb;

    localparam time CLK_PERIOD = 8;
    localparam int  RAND_N     = 64;
    localparam int  BUDGET_CYC = 20 + 64 * 4 + 24 + (RAND_N + 2) + 100; // Four cycles per check

    logic                  clk;
    logic                  arst_n_i;
    logic                  stall_i;
    logic                  flush_i;
    pipe_pkg::ex_result_t  ex_i;
    pipe_pkg::wb_t         wb_o;
    exc_pkg::exc_report_t  exc_o;
    logic                  eret_o;
    int                    checks     = 0;
    int                    errors     = 0;
    int                    err_mark   = 0;
    int                    ram_wr_cnt = 0;
    logic [7:0]            mem_model [4 * `MB_RAM_DEPTH]; // Byte view of the data RAM
    logic [`MB_DATA_W-1:0] base = 32'h100;

    mem_back_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (dut_i.ram_we === 1'b1) ram_wr_cnt <= ram_wr_cnt + 1;
    end

    initial begin
        #(CLK_PERIOD * BUDGET_CYC);
        $display("Watchdog expired after %0d cycles before the tests finished", BUDGET_CYC);
        $display("Simulation failed");
        $finish;
    end

    task automatic cmp_wb(input string sig, input pipe_pkg::wb_t got, input pipe_pkg::wb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, sig, got, exp);
        end
    endtask

    task automatic cmp_exc(input string sig, input exc_pkg::exc_report_t got,
                           input exc_pkg::exc_report_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, sig, got, exp);
        end
    endtask

    task automatic cmp_flag(input string sig, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %b expected %b", $time, sig, got, exp);
        end
    endtask

    task automatic cmp_count(input string sig, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail at %0t: %s got %0d expected %0d", $time, sig, got, exp);
        end
    endtask

    function automatic pipe_pkg::ex_result_t alu_instr(input logic [31:0] pc,
                                                       input logic [4:0] dst, input logic [31:0] res);
        pipe_pkg::ex_result_t ins;
        ins           = '0;
        ins.pc        = pc;
        ins.alu_res   = res;
        ins.w_reg_ena = 1'b1;
        ins.w_reg_dst = dst;
        return ins;
    endfunction

    function automatic pipe_pkg::ex_result_t mem_instr(input logic [31:0] pc,
        input pipe_pkg::ls_sel_e sel, input logic [31:0] addr, input logic [31:0] rt);
        pipe_pkg::ex_result_t ins;
        ins         = '0;
        ins.pc      = pc;
        ins.alu_res = addr;
        ins.ls_addr = addr;
        ins.rt_data = rt;
        ins.ls_ena  = 1'b1;
        ins.ls_sel  = sel;
        if (sel < pipe_pkg::LS_SB) begin
            ins.w_reg_ena  = 1'b1;
            ins.w_reg_dst  = 5'd3;
            ins.wb_reg_sel = 1'b1;
        end
        return ins;
    endfunction

    function automatic exc_pkg::exc_report_t exc_rep(input exc_pkg::exc_code_e code,
                                                     input logic [31:0] epc, input logic [31:0] bad);
        exc_pkg::exc_report_t r;
        r.valid     = 1'b1;
        r.code      = code;
        r.epc       = epc;
        r.bad_vaddr = bad;
        return r;
    endfunction

    function automatic logic [31:0] load_expect(input pipe_pkg::ls_sel_e sel, input logic [31:0] addr);
        int unsigned idx;
        logic [15:0] h;
        idx = addr[`MB_RAM_AW+1:0];
        h   = {mem_model[idx+1], mem_model[idx]}; // Little endian lanes
        case (sel)
            pipe_pkg::LS_LB:  return {{24{mem_model[idx][7]}}, mem_model[idx]};
            pipe_pkg::LS_LBU: return {24'h0, mem_model[idx]};
            pipe_pkg::LS_LH:  return {{16{h[15]}}, h};
            pipe_pkg::LS_LHU: return {16'h0, h};
            default:          return {mem_model[idx+3], mem_model[idx+2], h};
        endcase
    endfunction

    // Runs one instruction with an ALU follower and checks both against the flush rule
    task automatic check_instr(input pipe_pkg::ex_result_t ins, input exc_pkg::exc_report_t exp_exc,
                               input logic exp_eret, input pipe_pkg::wb_t exp_wb);
        pipe_pkg::ex_result_t foll;
        pipe_pkg::wb_t        foll_wb;
        foll    = alu_instr(ins.pc + 4, 5'd31, ins.pc ^ 32'h5a5a_0000);
        foll_wb = {1'b1, 5'd31, foll.alu_res};
        if (exp_exc.valid || exp_eret) begin
            exp_wb  = '0;
            foll_wb = '0;
        end
        @(negedge clk);
        ex_i = ins;
        @(negedge clk);
        cmp_exc("exc_o", exc_o, exp_exc);
        cmp_flag("eret_o", eret_o, exp_eret);
        ex_i = foll;
        @(negedge clk);
        cmp_wb("wb_o", wb_o, exp_wb);
        ex_i = '0;
        @(negedge clk);
        cmp_wb("wb_o of follower", wb_o, foll_wb);
    endtask

    task automatic store_word(input pipe_pkg::ls_sel_e sel, input logic [31:0] addr,
                              input logic [31:0] data);
        int unsigned idx;
        idx = addr[`MB_RAM_AW+1:0];
        check_instr(mem_instr(addr, sel, addr, data), '0, 1'b0, {1'b0, 5'd0, addr});
        mem_model[idx] = data[7:0];
        if (sel != pipe_pkg::LS_SB) mem_model[idx+1] = data[15:8];
        if (sel == pipe_pkg::LS_SW) {mem_model[idx+3], mem_model[idx+2]} = data[31:16];
    endtask

    task automatic load_value(input pipe_pkg::ls_sel_e sel, input logic [31:0] addr);
        check_instr(mem_instr(addr, sel, addr, 0), '0, 1'b0, {1'b1, 5'd3, load_expect(sel, addr)});
    endtask

    task automatic reset_values();
        @(negedge clk);
        cmp_wb("wb_o after reset", wb_o, '0);
        cmp_exc("exc_o after reset", exc_o, '0);
        cmp_flag("eret_o after reset", eret_o, 1'b0);
    endtask

    task automatic store_then_load();
        for (int w = 0; w < 3; w++) store_word(pipe_pkg::LS_SW, base + 4 * w, $urandom);
        for (int off = 0; off < 4; off += 2) store_word(pipe_pkg::LS_SH, base + 4 + off, $urandom);
        for (int off = 0; off < 4; off++) store_word(pipe_pkg::LS_SB, base + 8 + off, $urandom);
        for (int w = 0; w < 3; w++) begin
            load_value(pipe_pkg::LS_LW, base + 4 * w);
            for (int off = 0; off < 4; off++) begin
                load_value(pipe_pkg::LS_LB, base + 4 * w + off);
                load_value(pipe_pkg::LS_LBU, base + 4 * w + off);
                if (off % 2 == 0) begin
                    load_value(pipe_pkg::LS_LH, base + 4 * w + off);
                    load_value(pipe_pkg::LS_LHU, base + 4 * w + off);
                end
            end
        end
    endtask

    task automatic address_errors();
        check_instr(mem_instr(32'h400, pipe_pkg::LS_LW, base + 1, 0),
                    exc_rep(exc_pkg::EXC_ADEL, 32'h400, base + 1), 1'b0, '0);
        check_instr(mem_instr(32'h408, pipe_pkg::LS_SH, base + 5, 32'hdead_beef),
                    exc_rep(exc_pkg::EXC_ADES, 32'h408, base + 5), 1'b0, '0);
        load_value(pipe_pkg::LS_LW, base + 4); // The faulting store must not have landed
    endtask

    task automatic exception_priority();
        pipe_pkg::ex_result_t ins;
        ins = alu_instr(32'h800, 5'd4, 32'h1);
        {ins.exc.is_int, ins.exc.is_ri, ins.exc.is_overflow} = 3'b111;
        check_instr(ins, exc_rep(exc_pkg::EXC_INT, 32'h800, 0), 1'b0, '0);
        ins = alu_instr(32'h810, 5'd4, 32'h2);
        {ins.exc.is_inst_adel, ins.exc.is_ri} = 2'b11;
        check_instr(ins, exc_rep(exc_pkg::EXC_ADEL, 32'h810, 32'h810), 1'b0, '0);
        ins = alu_instr(32'h820, 5'd4, 32'h3);
        {ins.exc.is_ri, ins.exc.is_overflow, ins.exc.is_syscall} = 3'b111;
        check_instr(ins, exc_rep(exc_pkg::EXC_RI, 32'h820, 0), 1'b0, '0);
        ins = alu_instr(32'h830, 5'd4, 32'h4);
        {ins.exc.is_overflow, ins.exc.is_break, ins.exc.in_delay_slot} = 3'b111;
        check_instr(ins, exc_rep(exc_pkg::EXC_OV, 32'h82c, 0), 1'b0, '0); // Delay slot moves epc back
        ins = alu_instr(32'h840, 5'd4, 32'h5);
        {ins.exc.is_syscall, ins.exc.is_break, ins.exc.is_eret} = 3'b111;
        check_instr(ins, exc_rep(exc_pkg::EXC_SYS, 32'h840, 0), 1'b0, '0);
        ins = mem_instr(32'h850, pipe_pkg::LS_LW, base + 2, 0);
        ins.exc.is_break = 1'b1;
        check_instr(ins, exc_rep(exc_pkg::EXC_BP, 32'h850, 0), 1'b0, '0);
        ins = alu_instr(32'h860, 5'd4, 32'h6);
        ins.exc.is_eret = 1'b1;
        check_instr(ins, '0, 1'b1, '0);
    endtask

    task automatic stall_and_flush();
        logic [31:0]   data;
        pipe_pkg::wb_t held;
        int            cnt0;
        data = $urandom;
        held = {1'b1, 5'd7, 32'hcafe_0007};
        @(negedge clk);
        ex_i = alu_instr(32'hc00, 5'd7, 32'hcafe_0007);
        @(negedge clk);
        ex_i = mem_instr(32'hc04, pipe_pkg::LS_SW, base + 32'h10, data);
        @(negedge clk);
        ex_i    = '0;
        stall_i = 1'b1;
        cnt0    = ram_wr_cnt;
        cmp_wb("wb_o before stall", wb_o, held);
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            cmp_wb("wb_o under stall", wb_o, held);
            flush_i = (i == 0); // Ignored while stalled
        end
        flush_i = 1'b0;
        stall_i = 1'b0;
        repeat (3) @(negedge clk);
        cmp_count("data RAM writes of held store", ram_wr_cnt - cnt0, 1);
        {mem_model[base+19], mem_model[base+18], mem_model[base+17], mem_model[base+16]} = data;
        load_value(pipe_pkg::LS_LW, base + 32'h10);
        @(negedge clk);
        ex_i = alu_instr(32'hc10, 5'd9, 32'h0f0f_0009);
        @(negedge clk);
        ex_i    = alu_instr(32'hc14, 5'd10, 32'h0f0f_000a); // Dropped in the first register
        flush_i = 1'b1;
        @(negedge clk);
        ex_i    = '0;
        flush_i = 1'b0;
        cmp_wb("wb_o after flush", wb_o, '0);
        @(negedge clk);
        cmp_wb("wb_o behind flush", wb_o, '0);
    endtask

    task automatic random_alu_writeback();
        pipe_pkg::wb_t        exp_q [$];
        pipe_pkg::ex_result_t ins;
        for (int j = 0; j < RAND_N + 2; j++) begin
            @(negedge clk);
            if (j >= 2) cmp_wb("wb_o in random run", wb_o, exp_q.pop_front());
            ex_i = '0;
            if (j < RAND_N) begin
                ins  = alu_instr(32'h1000 + 4 * j, 5'($urandom), $urandom);
                ex_i = ins;
                exp_q.push_back({1'b1, ins.w_reg_dst, ins.alu_res});
            end
        end
    endtask

    task automatic report_test(input string name);
        $display("Test %s finished with %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        void'($urandom(10929));
        arst_n_i = 1'b0;
        stall_i  = 1'b0;
        flush_i  = 1'b0;
        ex_i     = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        reset_values();
        report_test("reset");
        store_then_load();
        report_test("store_load");
        address_errors();
        report_test("addr_errors");
        exception_priority();
        report_test("exc_priority");
        stall_and_flush();
        report_test("stall_flush");
        random_alu_writeback();
        report_test("random_alu");
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_back.f ====
+incdir+.
exc_pkg.sv
pipe_pkg.sv
pipe_reg.sv
exc_arbiter.sv
lsu_addr_stage.sv
data_ram.sv
load_align.sv
mem_back_top.sv
mem_back_asserts.sv
mem_back_tb.sv

// ==== Bender.yml ====
package:
  name: mem_back

sources:
  - include_dirs:
      - .
    files:
      - exc_pkg.sv
      - pipe_pkg.sv
      - pipe_reg.sv
      - exc_arbiter.sv
      - lsu_addr_stage.sv
      - data_ram.sv
      - load_align.sv
      - mem_back_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - mem_back_asserts.sv
      - mem_back_tb.sv
